//--- Makefile
# verilator build and run of the max pooling testbench

SRCS := $(filter-out +%,$(shell cat pool_max.f))
BIN  := obj_dir/Vpool_max_tb

.PHONY: run clean

# pass only when the testbench prints its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

# rebuilt only when a source, the header or the file list changes
$(BIN): pool_max.f $(SRCS) include/pool_max_regs.svh
	verilator --binary --timing --assert -Wno-fatal -f pool_max.f \
		--top-module pool_max_tb

clean:
	rm -rf obj_dir

//--- include/pool_max_regs.svh
`ifndef POOL_MAX_REGS_SVH
`define POOL_MAX_REGS_SVH

//////////////////////////////
// register map
//////////////////////////////

// window length, write only legal 1..MAX_WINDOW
`define REG_CTRL    4'h0
// sample input, fp16 in bits 15..0
`define REG_SAMPLE  4'h4
// queue head, read pops
`define REG_RESULT  4'h8
// status, write bit 6 to clear overflow
`define REG_STATUS  4'hC

// status word fields
`define STAT_COUNT_MSB  3
`define STAT_COUNT_LSB  0
`define STAT_EMPTY      4
`define STAT_FULL       5
`define STAT_OVF        6
`define STAT_PARTIAL    7

`endif

//--- pool_max.f
+incdir+include
verilog/pool_max_pkg.sv
verilog/fp16_compare.sv
verilog/max_pool_core.sv
verilog/result_fifo.sv
verilog/pool_max_apb.sv
verilog/pool_max_top.sv
testbench/pool_max_properties.sv
testbench/pool_max_tb.sv

//--- testbench/pool_max_properties.sv
`timescale 1ns/1ps

module pool_max_properties #(
    parameter int FIFO_DEPTH = 4
) (
    input logic                             clk,
    input logic                             rstn,
    input logic                             pready,
    input pool_max_pkg::result_s            result,
    input logic [$clog2(FIFO_DEPTH+1)-1:0] count,
    input logic                             overflow,
    input logic                             clr_ovf
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    //////////////////////////////
    // apb
    //////////////////////////////

    // zero wait state slave
    a_pready_high: assert property (@(posedge clk) disable iff (!rstn) pready)
        else $error("pready went low");

    //////////////////////////////
    // core and queue
    //////////////////////////////

    // queue can never hold more than its depth
    a_count_bound: assert property (@(posedge clk) disable iff (!rstn)
        count <= CNT_W'(FIFO_DEPTH))
        else $error("queue count above depth");

    // one strobe per finished window
    a_result_pulse: assert property (@(posedge clk) disable iff (!rstn)
        result.valid |=> !result.valid)
        else $error("result valid held for more than one cycle");

    // sticky until software clears it
    a_ovf_sticky: assert property (@(posedge clk) disable iff (!rstn)
        (overflow && !clr_ovf) |=> overflow)
        else $error("overflow dropped without a clear");

endmodule

bind pool_max_top pool_max_properties #(
    .FIFO_DEPTH (FIFO_DEPTH)
) u_props (
    .clk      (clk),
    .rstn     (rstn),
    .pready   (pready),
    .result   (result),
    .count    (count),
    .overflow (overflow),
    .clr_ovf  (clr_ovf)
);

//--- testbench/pool_max_tb.sv
`timescale 1ns/1ps

`include "pool_max_regs.svh"

module pool_max_tb;

    localparam int FIFO_DEPTH = 4;
    localparam int MAX_WINDOW = 16;
    // cycles or polls before giving up
    localparam int TIMEOUT    = 100;

    logic        clk;
    logic        rstn;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // reference model state
    pool_max_pkg::fp16_t expq[$];
    pool_max_pkg::fp16_t cur_win[$];
    int                  win_len_m;
    logic                ovf_m;
    int                  n_errors;
    int                  n_checks;

    pool_max_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .MAX_WINDOW (MAX_WINDOW)
    ) u_dut (
        .clk     (clk),
        .rstn    (rstn),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic abort_run(string why);
        $display("Error: %s", why);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic compare_fp16(string name, pool_max_pkg::fp16_t got,
                                pool_max_pkg::fp16_t exp);
        n_checks++;
        if (got.raw !== exp.raw) begin
            $display("Fail at %0t: %s got 0x%h expected 0x%h", $time, name, got.raw, exp.raw);
            n_errors++;
        end
    endtask

    task automatic compare_status(string name, logic [31:0] got, logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
            n_errors++;
        end
    endtask

    task automatic compare_err(string name, logic got, logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
            n_errors++;
        end
    endtask

    //////////////////////////////
    // apb master
    //////////////////////////////

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        // setup phase
        paddr   <= addr;
        pwrite  <= 1'b1;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        // sample mid cycle, away from the edges
        @(negedge clk);
        while (!pready && waits < TIMEOUT) begin
            waits++;
            @(negedge clk);
        end
        if (!pready) begin
            abort_run("apb write never saw pready");
        end else begin
            err = pslverr;
            @(posedge clk);
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waits < TIMEOUT) begin
            waits++;
            @(negedge clk);
        end
        if (!pready) begin
            abort_run("apb read never saw pready");
        end else begin
            data = prdata;
            err  = pslverr;
            @(posedge clk);
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    // signed magnitude to integer, both zeros land on 0
    function automatic int order_key(pool_max_pkg::fp16_t v);
        return v.raw[15] ? -int'(v.raw[14:0]) : int'(v.raw[14:0]);
    endfunction

    function automatic pool_max_pkg::fp16_t window_max();
        pool_max_pkg::fp16_t best;
        logic                saw_nan;
        best    = cur_win[0];
        saw_nan = 1'b0;
        foreach (cur_win[i]) begin
            pool_max_pkg::fp16_t s;
            s = cur_win[i];
            if (s.raw[14:10] == 5'h1F && s.raw[9:0] != 10'h0) begin
                saw_nan = 1'b1;
            end else if (order_key(s) > order_key(best)) begin
                // strictly greater, so ties keep the earlier one
                best = s;
            end
        end
        if (saw_nan) begin
            best.raw = 16'h7E00;
        end
        return best;
    endfunction

    function automatic logic [31:0] model_status();
        logic [31:0] s;
        s = '0;
        s[`STAT_COUNT_MSB:`STAT_COUNT_LSB] = 4'(expq.size());
        s[`STAT_EMPTY]   = (expq.size() == 0);
        s[`STAT_FULL]    = (expq.size() == FIFO_DEPTH);
        s[`STAT_OVF]     = ovf_m;
        s[`STAT_PARTIAL] = (cur_win.size() != 0);
        return s;
    endfunction

    function automatic pool_max_pkg::fp16_t random_finite();
        pool_max_pkg::fp16_t v;
        v.raw = 16'($urandom);
        // move off the inf/nan exponent
        if (v.raw[14:10] == 5'h1F) begin
            v.raw[14:10] = 5'h1E;
        end
        return v;
    endfunction

    //////////////////////////////
    // driver steps
    //////////////////////////////

    task automatic set_len(int len, logic exp_err);
        logic err;
        apb_write(`REG_CTRL, 32'(len), err);
        compare_err("pslverr", err, exp_err);
        // a good length restarts the window
        if (!exp_err) begin
            win_len_m = len;
            cur_win.delete();
        end
    endtask

    task automatic send_sample(pool_max_pkg::fp16_t v);
        logic err;
        apb_write(`REG_SAMPLE, {16'h0000, v.raw}, err);
        compare_err("pslverr", err, 1'b0);
        cur_win.push_back(v);
        if (cur_win.size() == win_len_m) begin
            if (expq.size() < FIFO_DEPTH) begin
                expq.push_back(window_max());
            end else begin
                ovf_m = 1'b1;
            end
            cur_win.delete();
        end
    endtask

    task automatic send_raw(logic [15:0] r);
        pool_max_pkg::fp16_t v;
        v.raw = r;
        send_sample(v);
    endtask

    // poll status until it matches the model
    task automatic sync_status(string name);
        logic [31:0] got;
        logic [31:0] exp;
        logic        err;
        int          polls;
        exp   = model_status();
        polls = 0;
        apb_read(`REG_STATUS, got, err);
        while (got !== exp && polls < TIMEOUT) begin
            polls++;
            apb_read(`REG_STATUS, got, err);
        end
        if (got !== exp) begin
            $display("Error: status poll timed out at %s", name);
        end
        compare_err("pslverr", err, 1'b0);
        compare_status(name, got, exp);
    endtask

    task automatic read_result();
        logic [31:0]         data;
        logic                err;
        pool_max_pkg::fp16_t got;
        if (expq.size() == 0) begin
            abort_run("result read with no result expected");
        end else begin
            apb_read(`REG_RESULT, data, err);
            compare_err("pslverr", err, 1'b0);
            got.raw = data[15:0];
            compare_fp16("result", got, expq.pop_front());
        end
    endtask

    task automatic collect_result();
        sync_status("status");
        read_result();
    endtask

    task automatic clear_overflow();
        logic err;
        apb_write(`REG_STATUS, 32'h1 << `STAT_OVF, err);
        compare_err("pslverr", err, 1'b0);
        ovf_m = 1'b0;
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic random_windows();
        set_len(4, 1'b0);
        // +0 first, then -0 ties it
        send_raw(16'h0000);
        send_raw(16'h8000);
        send_raw(16'hBC00);
        send_raw(16'h8000);
        collect_result();
        // -0 first must survive the later +0
        send_raw(16'h8000);
        send_raw(16'hC000);
        send_raw(16'h0000);
        send_raw(16'hBC00);
        collect_result();
        for (int w = 0; w < 8; w++) begin
            for (int k = 0; k < 4; k++) begin
                send_sample(random_finite());
            end
            collect_result();
        end
    endtask

    task automatic nan_windows();
        // nan as last sample of a window
        send_raw(16'h3C00);
        send_raw(16'h4000);
        send_raw(16'hBC00);
        send_raw(16'h7C01);
        collect_result();
        // nan as first sample of a window
        send_raw(16'hFE01);
        send_raw(16'h3C00);
        send_raw(16'h3C00);
        send_raw(16'h3C00);
        collect_result();
        // next window is clean, infinities order normally
        send_raw(16'hFC00);
        send_raw(16'hC400);
        send_raw(16'h7C00);
        send_raw(16'h3C00);
        collect_result();
    endtask

    task automatic window_lengths();
        set_len(1, 1'b0);
        for (int i = 0; i < 3; i++) begin
            send_sample(random_finite());
            collect_result();
        end
        set_len(16, 1'b0);
        set_len(0, 1'b1);
        set_len(17, 1'b1);
        // still 16, so no result after 15
        for (int i = 0; i < 15; i++) begin
            send_sample(random_finite());
        end
        sync_status("status");
        send_sample(random_finite());
        collect_result();
    endtask

    task automatic mid_window_restart();
        set_len(4, 1'b0);
        send_sample(random_finite());
        send_sample(random_finite());
        sync_status("status");
        set_len(4, 1'b0);
        sync_status("status");
        for (int i = 0; i < 4; i++) begin
            send_sample(random_finite());
        end
        collect_result();
    endtask

    task automatic queue_overflow();
        set_len(1, 1'b0);
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            send_sample(random_finite());
        end
        sync_status("status");
        clear_overflow();
        sync_status("status");
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            read_result();
        end
        sync_status("status");
    endtask

    task automatic error_responses();
        logic [31:0] data;
        logic        err;
        apb_read(`REG_RESULT, data, err);
        compare_err("pslverr", err, 1'b1);
        sync_status("status");
        apb_write(4'h2, 32'h0000_3C00, err);
        compare_err("pslverr", err, 1'b1);
        // one entry queued, then an unmapped read
        send_sample(random_finite());
        sync_status("status");
        apb_read(4'hE, data, err);
        compare_err("pslverr", err, 1'b1);
        sync_status("status");
        read_result();
    endtask

    //////////////////////////////
    // main
    //////////////////////////////

    initial begin
        void'($urandom(93));
        rstn      = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        win_len_m = 1;
        ovf_m     = 1'b0;
        n_errors  = 0;
        n_checks  = 0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        sync_status("status");
        random_windows();
        nan_windows();
        window_lengths();
        mid_window_restart();
        queue_overflow();
        error_responses();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/fp16_compare.sv
`timescale 1ns/1ps

module fp16_compare (
    input  pool_max_pkg::fp16_t a,
    input  pool_max_pkg::fp16_t b,
    output logic                a_gt_b,
    output logic                any_nan
);

    logic        a_nan;
    logic        b_nan;
    logic [14:0] a_mag;
    logic [14:0] b_mag;
    logic        both_zero;

    // nan: exponent all ones, mantissa nonzero
    assign a_nan = (&a.fld.exponent) & (|a.fld.mantissa);
    assign b_nan = (&b.fld.exponent) & (|b.fld.mantissa);
    assign any_nan = a_nan | b_nan;

    // magnitude without sign, inf sits above every finite value
    assign a_mag = {a.fld.exponent, a.fld.mantissa};
    assign b_mag = {b.fld.exponent, b.fld.mantissa};

    // +0 and -0 are the same value
    assign both_zero = (a_mag == 15'd0) && (b_mag == 15'd0);

    always_comb begin
        a_gt_b = 1'b0;
        if (any_nan || both_zero) begin
            // unordered or equal, never greater
            a_gt_b = 1'b0;
        end else begin
            case ({a.fld.sign, b.fld.sign})
                // both positive
                2'b00: a_gt_b = (a_mag > b_mag);
                // a positive, b negative
                2'b01: a_gt_b = 1'b1;
                // a negative, b positive
                2'b10: a_gt_b = 1'b0;
                // both negative, smaller magnitude wins
                2'b11: a_gt_b = (a_mag < b_mag);
                default: a_gt_b = 1'b0;
            endcase
        end
    end

endmodule

//--- verilog/max_pool_core.sv
`timescale 1ns/1ps

module max_pool_core #(
    parameter int MAX_WINDOW = 16
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  pool_max_pkg::sample_s   sample,
    input  pool_max_pkg::pool_cfg_s cfg,
    output pool_max_pkg::result_s   result,
    output logic                    partial
);

    localparam int CNT_W = $clog2(MAX_WINDOW + 1);

    logic [CNT_W-1:0]    cnt;
    logic [CNT_W-1:0]    cnt_next;
    logic                nan_q;
    pool_max_pkg::fp16_t max_q;
    pool_max_pkg::fp16_t cmp_b;
    pool_max_pkg::fp16_t max_next;
    logic                first;
    logic                last;
    logic                a_gt_b;
    logic                any_nan;
    logic                res_valid;
    pool_max_pkg::fp16_t res_data;

    //////////////////////////////
    // compare
    //////////////////////////////

    assign first    = (cnt == '0);
    assign cnt_next = cnt + 1'b1;
    // win_len never exceeds MAX_WINDOW, so the cast keeps every legal value
    assign last     = (cnt_next == CNT_W'(cfg.win_len));

    // first sample compares against itself so a stale max can't flag nan
    assign cmp_b = first ? sample.data : max_q;

    fp16_compare u_cmp (
        .a       (sample.data),
        .b       (cmp_b),
        .a_gt_b  (a_gt_b),
        .any_nan (any_nan)
    );

    // strictly greater only, ties keep the earlier sample
    assign max_next = (first || a_gt_b) ? sample.data : max_q;

    //////////////////////////////
    // window state
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt       <= '0;
            nan_q     <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            if (cfg.restart) begin
                // drop whatever partial window there is
                cnt   <= '0;
                nan_q <= 1'b0;
            end else if (sample.valid) begin
                if (last) begin
                    cnt       <= '0;
                    nan_q     <= 1'b0;
                    res_valid <= 1'b1;
                end else begin
                    cnt   <= cnt_next;
                    nan_q <= nan_q | any_nan;
                end
            end
        end
    end

    // running max and result word
    always_ff @(posedge clk) begin
        if (sample.valid) begin
            max_q <= max_next;
            if (last) begin
                // nan anywhere in the window wins
                res_data <= (nan_q || any_nan) ? pool_max_pkg::FP16_QNAN : max_next;
            end
        end
    end

    assign result.valid = res_valid;
    assign result.data  = res_data;
    assign partial      = (cnt != '0);

endmodule

//--- verilog/pool_max_apb.sv
`timescale 1ns/1ps

`include "pool_max_regs.svh"

module pool_max_apb #(
    parameter int FIFO_DEPTH = 4,
    parameter int MAX_WINDOW = 16
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [3:0]                       paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [31:0]                      pwdata,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr,
    output pool_max_pkg::sample_s            sample,
    output pool_max_pkg::pool_cfg_s          cfg,
    input  logic                             partial,
    input  pool_max_pkg::fp16_t              head,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0] count,
    input  logic                             full,
    input  logic                             overflow,
    output logic                             pop,
    output logic                             clr_ovf
);

    logic                access;
    logic                wr;
    logic                rd;
    logic                mapped;
    logic                empty;
    logic                len_bad;
    logic                ctrl_wr;
    logic                smp_wr;
    logic [4:0]          win_len_q;
    logic                restart_q;
    logic                smp_valid_q;
    pool_max_pkg::fp16_t smp_data_q;
    logic [31:0]         status;

    //////////////////////////////
    // decode
    //////////////////////////////

    // zero wait states, access phase always completes
    assign pready = 1'b1;
    assign access = psel & penable;
    assign wr     = access & pwrite;
    assign rd     = access & ~pwrite;

    assign mapped = (paddr == `REG_CTRL) || (paddr == `REG_SAMPLE) ||
                    (paddr == `REG_RESULT) || (paddr == `REG_STATUS);
    assign empty  = (count == '0);

    // window length must be 1..MAX_WINDOW
    assign len_bad = (pwdata == 32'd0) || (pwdata > 32'(MAX_WINDOW));

    assign ctrl_wr = wr && (paddr == `REG_CTRL) && !len_bad;
    assign smp_wr  = wr && (paddr == `REG_SAMPLE);

    // error cases, all in the access cycle
    assign pslverr = access && (!mapped ||
                     (pwrite && (paddr == `REG_CTRL) && len_bad) ||
                     (!pwrite && (paddr == `REG_RESULT) && empty));

    // queue controls act at the access edge
    assign pop     = rd && (paddr == `REG_RESULT) && !empty;
    assign clr_ovf = wr && (paddr == `REG_STATUS) && pwdata[`STAT_OVF];

    //////////////////////////////
    // config and sample regs
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            win_len_q   <= 5'd1;
            restart_q   <= 1'b0;
            smp_valid_q <= 1'b0;
        end else begin
            // pulses, one cycle after the access
            restart_q   <= ctrl_wr;
            smp_valid_q <= smp_wr;
            if (ctrl_wr) begin
                win_len_q <= pwdata[4:0];
            end
        end
    end

    // sample word, no reset needed under valid
    always_ff @(posedge clk) begin
        if (smp_wr) begin
            smp_data_q <= pwdata[15:0];
        end
    end

    assign sample.valid = smp_valid_q;
    assign sample.data  = smp_data_q;
    assign cfg.win_len  = win_len_q;
    assign cfg.restart  = restart_q;

    //////////////////////////////
    // read side
    //////////////////////////////

    always_comb begin
        status = '0;
        status[`STAT_COUNT_MSB:`STAT_COUNT_LSB] = 4'(count);
        status[`STAT_EMPTY]   = empty;
        status[`STAT_FULL]    = full;
        status[`STAT_OVF]     = overflow;
        status[`STAT_PARTIAL] = partial;
    end

    // read mux, sample register reads back as zero
    always_comb begin
        case (paddr)
            `REG_CTRL:   prdata = 32'(win_len_q);
            `REG_RESULT: prdata = 32'(head.raw);
            `REG_STATUS: prdata = status;
            default:     prdata = '0;
        endcase
    end

endmodule

//--- verilog/pool_max_pkg.sv
package pool_max_pkg;

    //////////////////////////////
    // fp16 word
    //////////////////////////////

    // ieee half precision fields
    typedef struct packed {
        logic       sign;
        logic [4:0] exponent;
        logic [9:0] mantissa;
    } fp16_fields_s;

    // raw view for storage, field view for the comparator
    typedef union packed {
        logic [15:0]  raw;
        fp16_fields_s fld;
    } fp16_t;

    // canonical quiet nan, returned for any window holding a nan
    localparam logic [15:0] FP16_QNAN = 16'h7E00;

    //////////////////////////////
    // stream structs
    //////////////////////////////

    // one sample, apb slave to core
    typedef struct packed {
        logic  valid;
        fp16_t data;
    } sample_s;

    // one window maximum, core to queue
    typedef struct packed {
        logic  valid;
        fp16_t data;
    } result_s;

    // window config from REG_CTRL
    typedef struct packed {
        // 1..16
        logic [4:0] win_len;
        // single cycle, on each length write
        logic       restart;
    } pool_cfg_s;

endpackage

//--- verilog/pool_max_top.sv
`timescale 1ns/1ps

module pool_max_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int MAX_WINDOW = 16
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // apb to core
    pool_max_pkg::sample_s   sample;
    pool_max_pkg::pool_cfg_s cfg;
    logic                    partial;
    // core to queue
    pool_max_pkg::result_s   result;
    // queue to apb and back
    pool_max_pkg::fp16_t     head;
    logic [CNT_W-1:0]        count;
    logic                    full;
    logic                    overflow;
    logic                    pop;
    logic                    clr_ovf;

    //////////////////////////////
    // blocks
    //////////////////////////////

    pool_max_apb #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .MAX_WINDOW (MAX_WINDOW)
    ) u_apb (
        .clk      (clk),
        .rstn     (rstn),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .sample   (sample),
        .cfg      (cfg),
        .partial  (partial),
        .head     (head),
        .count    (count),
        .full     (full),
        .overflow (overflow),
        .pop      (pop),
        .clr_ovf  (clr_ovf)
    );

    max_pool_core #(
        .MAX_WINDOW (MAX_WINDOW)
    ) u_core (
        .clk     (clk),
        .rstn    (rstn),
        .sample  (sample),
        .cfg     (cfg),
        .result  (result),
        .partial (partial)
    );

    result_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rstn     (rstn),
        .result   (result),
        .pop      (pop),
        .clr_ovf  (clr_ovf),
        .head     (head),
        .count    (count),
        .full     (full),
        .overflow (overflow)
    );

endmodule

//--- verilog/result_fifo.sv
`timescale 1ns/1ps

module result_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  pool_max_pkg::result_s            result,
    input  logic                             pop,
    input  logic                             clr_ovf,
    output pool_max_pkg::fp16_t              head,
    output logic [$clog2(FIFO_DEPTH+1)-1:0] count,
    output logic                             full,
    output logic                             overflow
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    pool_max_pkg::fp16_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    cnt_q;
    logic                empty;
    logic                do_pop;
    logic                do_push;
    logic                drop;

    assign empty = (cnt_q == '0);
    assign full  = (cnt_q == CNT_W'(FIFO_DEPTH));

    // pop on empty ignored
    assign do_pop  = pop & ~empty;
    // a slot freed by a same cycle pop takes the push
    assign do_push = result.valid & (~full | do_pop);
    assign drop    = result.valid & full & ~do_pop;

    //////////////////////////////
    // pointers and count
    //////////////////////////////

    // depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            cnt_q    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
            // sticky, a new drop beats the clear
            if (drop) begin
                overflow <= 1'b1;
            end else if (clr_ovf) begin
                overflow <= 1'b0;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= result.data;
        end
    end

    assign head  = mem[rd_ptr];
    assign count = cnt_q;

endmodule
